// ==== spd_consts.svh ====
`ifndef SPD_CONSTS_SVH
`define SPD_CONSTS_SVH

// i2c address scan range, address 0 is the general call
`define SPD_ADDR_FIRST 1
`define SPD_ADDR_LAST 127

// spd bytes read after the address is found
`define SPD_LAST_BYTE 63

// byte 2 device type code of a ddr3 sdram
`define SPD_DDR3_TYPE 8'h0B

// longest text line including its line feed
`define TEXT_MAX_CHARS 24

`define UART_CLKS_PER_BIT 8

`endif

// ==== spd_pkg.sv ====
package spd_pkg;

    // 7-bit i2c device address
    typedef logic [6:0] i2c_addr_t;

    // spd byte number, only bytes 0 to 63 are read
    typedef logic [5:0] spd_index_t;

    // spd byte value, also the width of the register field on the bus
    typedef logic [7:0] spd_byte_t;

endpackage

// ==== text_pkg.sv ====
`include "spd_consts.svh"

package text_pkg;

    typedef logic [7:0] char_t; // ascii

    // first character sits in the top byte
    typedef logic [`TEXT_MAX_CHARS*8-1:0] text_t;

    typedef logic [4:0] text_len_t; // number of valid characters

endpackage

// ==== spd_scan_ctrl.sv ====
`include "spd_consts.svh"

module spd_scan_ctrl (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    output logic                  o_rd_req,
    output spd_pkg::i2c_addr_t    o_rd_dev,
    output spd_pkg::spd_byte_t    o_rd_reg,
    input  logic                  i_rd_ack,
    input  spd_pkg::spd_byte_t    i_rd_data,
    input  logic                  i_rd_nack,
    output logic                  o_line_req,
    output logic                  o_line_is_addr,
    output spd_pkg::spd_index_t   o_line_index,
    output spd_pkg::spd_byte_t    o_line_value,
    input  logic                  i_line_ack,
    output logic                  o_addr_found,
    output logic                  o_read_done,
    output logic                  o_read_err
);
    import spd_pkg::*;

    typedef enum logic [2:0] {
        st_start,
        st_rd_wait,  // req high, waiting for ack
        st_rd_rel,   // req low, waiting for ack to drop
        st_line_wait,
        st_line_rel,
        st_halt
    } state_t;

    state_t     state;
    spd_index_t idx;
    spd_byte_t  data_q;
    logic       nack_q;

    // scan phase lasts until the address line is out
    assign o_line_is_addr = !o_addr_found;
    assign o_rd_reg       = {2'b00, idx}; // idx stays 0 while scanning
    assign o_line_index   = idx;
    assign o_line_value   = o_line_is_addr ? {1'b0, o_rd_dev} : data_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= st_start;
            o_rd_req     <= 1'b0;
            o_rd_dev     <= i2c_addr_t'(`SPD_ADDR_FIRST);
            idx          <= '0;
            nack_q       <= 1'b0;
            o_line_req   <= 1'b0;
            o_addr_found <= 1'b0;
            o_read_done  <= 1'b0;
            o_read_err   <= 1'b0;
        end else begin
            case (state)
                st_start: begin
                    o_rd_req <= 1'b1;
                    state    <= st_rd_wait;
                end
                st_rd_wait: if (i_rd_ack) begin
                    o_rd_req <= 1'b0;
                    nack_q   <= i_rd_nack;
                    state    <= st_rd_rel;
                end
                st_rd_rel: if (!i_rd_ack) begin
                    if (!nack_q) begin
                        o_line_req <= 1'b1; // address line or byte line
                        state      <= st_line_wait;
                    end else if (o_addr_found) begin
                        o_read_err <= 1'b1; // device went away mid-read
                        state      <= st_halt;
                    end else if (o_rd_dev == i2c_addr_t'(`SPD_ADDR_LAST)) begin
                        o_read_err <= 1'b1; // nobody answered
                        state      <= st_halt;
                    end else begin
                        o_rd_dev <= o_rd_dev + 1'b1;
                        o_rd_req <= 1'b1;
                        state    <= st_rd_wait;
                    end
                end
                st_line_wait: if (i_line_ack) begin
                    o_line_req <= 1'b0;
                    state      <= st_line_rel;
                end
                st_line_rel: if (!i_line_ack) begin
                    if (!o_addr_found) begin
                        o_addr_found <= 1'b1;
                        o_rd_req     <= 1'b1; // byte 0 again, this time for real
                        state        <= st_rd_wait;
                    end else if (idx == spd_index_t'(`SPD_LAST_BYTE)) begin
                        o_read_done <= 1'b1;
                        state       <= st_halt;
                    end else begin
                        idx      <= idx + 1'b1;
                        o_rd_req <= 1'b1;
                        state    <= st_rd_wait;
                    end
                end
                default: state <= st_halt;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_rd_req && i_rd_ack) begin
            data_q <= i_rd_data;
        end
    end

    // four-phase bus rules toward the outside responder
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_rd_req && !i_rd_ack |=> o_rd_req);

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_rd_req && !i_rd_ack |=> $stable(o_rd_dev) && $stable(o_rd_reg));

endmodule

// ==== spd_line_fmt.sv ====
`include "spd_consts.svh"

module spd_line_fmt (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_line_req,
    input  logic                  i_line_is_addr,
    input  spd_pkg::spd_index_t   i_line_index,
    input  spd_pkg::spd_byte_t    i_line_value,
    output logic                  o_line_ack,
    output logic                  o_text_req,
    output text_pkg::text_t       o_text,
    output text_pkg::text_len_t   o_text_len,
    input  logic                  i_text_ack
);
    import text_pkg::*;

    localparam char_t LF = 8'h0a;

    typedef enum logic [1:0] {st_idle, st_text, st_text_rel, st_ack} state_t;

    state_t    state;
    text_t     raw; // line right-aligned, moved to the top slot on capture
    text_len_t len;
    logic      has_line;

    function automatic char_t hex_char(input logic [3:0] nib);
        hex_char = (nib < 4'd10) ? 8'h30 + 8'(nib) : 8'h37 + 8'(nib);
    endfunction

    always_comb begin
        raw      = '0;
        len      = '0;
        has_line = 1'b0;
        if (i_line_is_addr) begin
            raw = {"I2C Address: 0x", hex_char({1'b0, i_line_value[6:4]}),
                   hex_char(i_line_value[3:0]), LF};
            len      = 5'd18;
            has_line = 1'b1;
        end else begin
            case (i_line_index)
                6'd2: begin
                    has_line = 1'b1;
                    if (i_line_value == `SPD_DDR3_TYPE) begin
                        raw = {"DRAM Type: DDR3 SDRAM", LF};
                        len = 5'd22;
                    end else begin
                        raw = {"DRAM Type: NOT DDR3!", LF};
                        len = 5'd21;
                    end
                end
                6'd3: begin
                    has_line = (i_line_value < 8'd4); // other codes are not reported
                    case (i_line_value)
                        8'd0: begin
                            raw = {"Module Type: Undefined!", LF};
                            len = 5'd24;
                        end
                        8'd1: begin
                            raw = {"Module Type: RDIMM", LF};
                            len = 5'd19;
                        end
                        8'd2: begin
                            raw = {"Module Type: UDIMM", LF};
                            len = 5'd19;
                        end
                        8'd3: begin
                            raw = {"Module Type: SO-DIMM", LF};
                            len = 5'd21;
                        end
                        default: ;
                    endcase
                end
                6'd7: begin
                    has_line = 1'b1;
                    len      = 5'd18;
                    raw = (i_line_value[5:3] == 3'd1) ? {"DUAL_RANK_DIMM: 1", LF}
                                                      : {"DUAL_RANK_DIMM: 0", LF};
                end
                6'd8: begin
                    has_line = (i_line_value[2:0] < 3'd4);
                    len      = 5'd14;
                    case (i_line_value[2:0]) // bus width 8 << n bits
                        3'd0: raw = {"BYTE_LANES: 1", LF};
                        3'd1: raw = {"BYTE_LANES: 2", LF};
                        3'd2: raw = {"BYTE_LANES: 4", LF};
                        3'd3: raw = {"BYTE_LANES: 8", LF};
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= st_idle;
            o_line_ack <= 1'b0;
            o_text_req <= 1'b0;
        end else begin
            case (state)
                st_idle: if (i_line_req) begin
                    if (has_line) begin
                        o_text_req <= 1'b1;
                        state      <= st_text;
                    end else begin
                        o_line_ack <= 1'b1; // nothing to print
                        state      <= st_ack;
                    end
                end
                st_text: if (i_text_ack) begin
                    o_text_req <= 1'b0;
                    state      <= st_text_rel;
                end
                st_text_rel: if (!i_text_ack) begin
                    o_line_ack <= 1'b1;
                    state      <= st_ack;
                end
                st_ack: if (!i_line_req) begin
                    o_line_ack <= 1'b0;
                    state      <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == st_idle && i_line_req && has_line) begin
            o_text     <= raw << (8 * (`TEXT_MAX_CHARS - int'(len)));
            o_text_len <= len;
        end
    end

endmodule

// ==== text_sender.sv ====
`include "spd_consts.svh"

module text_sender (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_text_req,
    input  text_pkg::text_t       i_text,
    input  text_pkg::text_len_t   i_text_len,
    output logic                  o_text_ack,
    output logic                  o_tx_req,
    output text_pkg::char_t       o_tx_char,
    input  logic                  i_tx_ack
);
    import text_pkg::*;

    typedef enum logic [1:0] {st_idle, st_char, st_char_rel, st_done} state_t;

    state_t    state;
    text_t     shreg; // current character always in the top byte
    text_len_t left;

    assign o_tx_char = shreg[`TEXT_MAX_CHARS*8-1 -: 8];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= st_idle;
            left       <= '0;
            o_tx_req   <= 1'b0;
            o_text_ack <= 1'b0;
        end else begin
            case (state)
                st_idle: if (i_text_req) begin
                    left     <= i_text_len;
                    o_tx_req <= 1'b1;
                    state    <= st_char;
                end
                st_char: if (i_tx_ack) begin
                    o_tx_req <= 1'b0;
                    state    <= st_char_rel;
                end
                st_char_rel: if (!i_tx_ack) begin
                    if (left == 5'd1) begin
                        o_text_ack <= 1'b1;
                        state      <= st_done;
                    end else begin
                        left     <= left - 1'b1;
                        o_tx_req <= 1'b1;
                        state    <= st_char;
                    end
                end
                st_done: if (!i_text_req) begin
                    o_text_ack <= 1'b0;
                    state      <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == st_idle && i_text_req) begin
            shreg <= i_text;
        end else if (state == st_char_rel && !i_tx_ack) begin
            shreg <= shreg << 8;
        end
    end

    // formatter must never hand over an empty or oversized line
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_text_req |-> (i_text_len != '0) && (i_text_len <= `TEXT_MAX_CHARS));

endmodule

// ==== uart_tx_serial.sv ====
`include "spd_consts.svh"

module uart_tx_serial #(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_tx_req,
    input  text_pkg::char_t   i_tx_char,
    output logic              o_tx_ack,
    output logic              o_uart_tx
);
    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    logic             busy;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_cnt; // 0 is the start bit, 9 the stop bit
    logic [8:0]       shreg;   // data lsb first, stop bit on top
    logic             start;
    logic             bit_end;

    assign start   = !busy && !o_tx_ack && i_tx_req;
    assign bit_end = busy && (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy      <= 1'b0;
            clk_cnt   <= '0;
            bit_cnt   <= '0;
            o_tx_ack  <= 1'b0;
            o_uart_tx <= 1'b1;
        end else if (start) begin
            busy      <= 1'b1;
            clk_cnt   <= '0;
            bit_cnt   <= '0;
            o_uart_tx <= 1'b0; // start bit
        end else if (!busy) begin
            if (o_tx_ack && !i_tx_req) o_tx_ack <= 1'b0;
        end else if (bit_end) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                busy     <= 1'b0; // line is already back at stop level
                o_tx_ack <= 1'b1;
            end else begin
                bit_cnt   <= bit_cnt + 1'b1;
                o_uart_tx <= shreg[0];
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (start) begin
            shreg <= {1'b1, i_tx_char};
        end else if (bit_end) begin
            shreg <= {1'b1, shreg[8:1]};
        end
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !busy |-> o_uart_tx);

endmodule

// ==== spd_reader.sv ====
module spd_reader (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    output logic                  o_rd_req,
    output spd_pkg::i2c_addr_t    o_rd_dev,
    output spd_pkg::spd_byte_t    o_rd_reg,
    input  logic                  i_rd_ack,
    input  spd_pkg::spd_byte_t    i_rd_data,
    input  logic                  i_rd_nack,
    output logic                  o_uart_tx,
    output logic                  o_addr_found,
    output logic                  o_read_done,
    output logic                  o_read_err
);
    import spd_pkg::*;
    import text_pkg::*;

    // scan controller to formatter
    logic       line_req;
    logic       line_ack;
    logic       line_is_addr;
    spd_index_t line_index;
    spd_byte_t  line_value;

    // formatter to text sender
    logic      text_req;
    logic      text_ack;
    text_t     text;
    text_len_t text_len;

    // text sender to uart
    logic  tx_req;
    logic  tx_ack;
    char_t tx_char;

    spd_scan_ctrl spd_scan_ctrl_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .o_rd_req       (o_rd_req),
        .o_rd_dev       (o_rd_dev),
        .o_rd_reg       (o_rd_reg),
        .i_rd_ack       (i_rd_ack),
        .i_rd_data      (i_rd_data),
        .i_rd_nack      (i_rd_nack),
        .o_line_req     (line_req),
        .o_line_is_addr (line_is_addr),
        .o_line_index   (line_index),
        .o_line_value   (line_value),
        .i_line_ack     (line_ack),
        .o_addr_found   (o_addr_found),
        .o_read_done    (o_read_done),
        .o_read_err     (o_read_err)
    );

    spd_line_fmt spd_line_fmt_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_line_req     (line_req),
        .i_line_is_addr (line_is_addr),
        .i_line_index   (line_index),
        .i_line_value   (line_value),
        .o_line_ack     (line_ack),
        .o_text_req     (text_req),
        .o_text         (text),
        .o_text_len     (text_len),
        .i_text_ack     (text_ack)
    );

    text_sender text_sender_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_text_req (text_req),
        .i_text     (text),
        .i_text_len (text_len),
        .o_text_ack (text_ack),
        .o_tx_req   (tx_req),
        .o_tx_char  (tx_char),
        .i_tx_ack   (tx_ack)
    );

    uart_tx_serial uart_tx_serial_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_tx_req  (tx_req),
        .i_tx_char (tx_char),
        .o_tx_ack  (tx_ack),
        .o_uart_tx (o_uart_tx)
    );

endmodule

// ==== tb_spd_reader.sv ====
`include "spd_consts.svh"

module tb_spd_reader;
    timeunit 1ns;
    timeprecision 100ps;

    import spd_pkg::*;
    import text_pkg::*;

    // twice the length of two full runs of scan, byte reads and text
    localparam int CYCLE_LIMIT = 2 * 2 * (127 + 64 * 12 + 150 * 10 * `UART_CLKS_PER_BIT);

    logic      clk;
    logic      rst_n;
    logic      rd_req;
    i2c_addr_t rd_dev;
    spd_byte_t rd_reg;
    logic      rd_ack;
    spd_byte_t rd_data;
    logic      rd_nack;
    logic      uart_tx;
    logic      addr_found;
    logic      read_done;
    logic      read_err;

    spd_byte_t mem [0:63];
    i2c_addr_t model_addr;
    int        nack_reg; // -1 when no register is refused
    int        seed;

    i2c_addr_t exp_dev_q[$];
    spd_byte_t exp_reg_q[$];
    char_t     exp_char_q[$];

    int    err_count;
    int    test_base;
    int    tests_run;
    int    tests_failed;
    int    rx_count;
    string rx_line;
    int    addr_line_len;
    int    cycles;

    spd_reader spd_reader_i (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .o_rd_req     (rd_req),
        .o_rd_dev     (rd_dev),
        .o_rd_reg     (rd_reg),
        .i_rd_ack     (rd_ack),
        .i_rd_data    (rd_data),
        .i_rd_nack    (rd_nack),
        .o_uart_tx    (uart_tx),
        .o_addr_found (addr_found),
        .o_read_done  (read_done),
        .o_read_err   (read_err)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run hung: no result after %0d clock cycles", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic check_char(input string what, input char_t got, input char_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s got 0x%02h expected 0x%02h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_reg(input string what, input spd_byte_t got, input spd_byte_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_dev(input string what, input i2c_addr_t got, input i2c_addr_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b expected %b", $time, what, got, exp);
            err_count++;
        end
    endtask

    // expected text for one spd byte or an empty string
    function automatic string line_for(input int idx, input spd_byte_t v);
        string s;
        s = "";
        case (idx)
            2: begin
                if (v == `SPD_DDR3_TYPE) s = "DRAM Type: DDR3 SDRAM";
                else s = "DRAM Type: NOT DDR3!";
            end
            3: begin
                case (v)
                    8'd0: s = "Module Type: Undefined!";
                    8'd1: s = "Module Type: RDIMM";
                    8'd2: s = "Module Type: UDIMM";
                    8'd3: s = "Module Type: SO-DIMM";
                    default: s = "";
                endcase
            end
            7: begin
                if (v[5:3] == 3'd1) s = "DUAL_RANK_DIMM: 1";
                else s = "DUAL_RANK_DIMM: 0";
            end
            8: begin
                if (v[2:0] < 3'd4) s = $sformatf("BYTE_LANES: %0d", 1 << v[2:0]);
            end
            default: s = "";
        endcase
        return s;
    endfunction

    function automatic void push_line(input string s);
        int i;
        if (s.len() > 0) begin
            for (i = 0; i < s.len(); i++) exp_char_q.push_back(s[i]);
            exp_char_q.push_back(8'h0a);
        end
    endfunction

    // new eeprom contents and the bus requests and text they should cause
    task automatic prepare_run(input int nack_at, input spd_byte_t b2, input spd_byte_t b3,
                               input spd_byte_t b7, input spd_byte_t b8);
        string digits;
        string addr_line;
        int    i;
        int    last;
        digits     = "0123456789ABCDEF";
        model_addr = i2c_addr_t'(2 + ($unsigned($random(seed)) % 126));
        for (i = 0; i < 64; i++) mem[i] = spd_byte_t'($random(seed));
        mem[2]   = b2;
        mem[3]   = b3;
        mem[7]   = b7;
        mem[8]   = b8;
        nack_reg = nack_at;
        exp_dev_q.delete();
        exp_reg_q.delete();
        exp_char_q.delete();
        rx_count = 0;
        for (i = `SPD_ADDR_FIRST; i <= model_addr; i++) begin
            exp_dev_q.push_back(i2c_addr_t'(i));
            exp_reg_q.push_back(8'd0);
        end
        addr_line = {"I2C Address: 0x", digits.substr(model_addr[6:4], model_addr[6:4]),
                     digits.substr(model_addr[3:0], model_addr[3:0])};
        addr_line_len = addr_line.len() + 1;
        push_line(addr_line);
        last = (nack_at >= 0) ? nack_at : `SPD_LAST_BYTE;
        for (i = 0; i <= last; i++) begin
            exp_dev_q.push_back(model_addr);
            exp_reg_q.push_back(spd_byte_t'(i));
            if (i != nack_at) push_line(line_for(i, mem[i]));
        end
        $display("run setup: eeprom at %0d, nack register %0d", model_addr, nack_at);
    endtask

    // eeprom side of the four-phase read port
    always begin : eeprom_model
        int delay;
        @(negedge clk);
        if (rst_n && rd_req && !rd_ack) begin
            if (exp_dev_q.size() == 0) begin
                $display("unexpected bus request to device %0d register %0d at %0t",
                         rd_dev, rd_reg, $time);
                err_count++;
            end else begin
                check_dev("request device", rd_dev, exp_dev_q.pop_front());
                check_reg("request register", rd_reg, exp_reg_q.pop_front());
            end
            delay = $unsigned($random(seed)) % 6;
            repeat (delay) @(negedge clk);
            rd_data = mem[rd_reg[5:0]];
            rd_nack = (rd_dev != model_addr) || (rd_reg == nack_reg);
            rd_ack  = 1'b1;
            @(negedge clk);
            while (rd_req) @(negedge clk);
            rd_ack = 1'b0;
        end
    end

    // samples mid-bit as the start bit is seen half a clock after it begins
    always begin : uart_rx
        char_t rx;
        int    b;
        @(negedge clk);
        if (rst_n && uart_tx === 1'b0) begin
            repeat (`UART_CLKS_PER_BIT / 2 - 1) @(negedge clk);
            if (uart_tx !== 1'b0) begin
                $display("uart start bit did not stay low at %0t", $time);
                err_count++;
            end
            rx = '0;
            for (b = 0; b < 8; b++) begin
                repeat (`UART_CLKS_PER_BIT) @(negedge clk);
                rx[b] = uart_tx;
            end
            repeat (`UART_CLKS_PER_BIT) @(negedge clk);
            if (uart_tx !== 1'b1) begin
                $display("uart stop bit missing at %0t", $time);
                err_count++;
            end
            rx_count++;
            if (exp_char_q.size() == 0) begin
                $display("unexpected uart character 0x%02h at %0t", rx, $time);
                err_count++;
            end else begin
                check_char("uart character", rx, exp_char_q.pop_front());
            end
            if (rx == 8'h0a) begin
                $display("rx line: %s", rx_line);
                rx_line = "";
            end else begin
                rx_line = $sformatf("%s%c", rx_line, rx);
            end
        end
    end

    task automatic check_idle_outputs();
        check_flag("o_rd_req in reset", rd_req, 1'b0);
        check_flag("o_uart_tx in reset", uart_tx, 1'b1);
        check_flag("o_addr_found in reset", addr_found, 1'b0);
        check_flag("o_read_done in reset", read_done, 1'b0);
        check_flag("o_read_err in reset", read_err, 1'b0);
    endtask

    task automatic apply_reset();
        int i;
        @(negedge clk);
        rst_n = 1'b0;
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            check_idle_outputs();
        end
        rst_n = 1'b1;
        @(negedge clk); // first clock edge out of reset
        check_flag("o_uart_tx after reset", uart_tx, 1'b1);
        check_flag("o_addr_found after reset", addr_found, 1'b0);
        check_flag("o_read_done after reset", read_done, 1'b0);
        check_flag("o_read_err after reset", read_err, 1'b0);
    endtask

    task automatic begin_test();
        test_base = err_count;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_count == test_base) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_count - test_base);
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        rd_ack       = 1'b0;
        rd_data      = '0;
        rd_nack      = 1'b0;
        seed         = 7;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        rx_line      = "";
        cycles       = 0;

        // ddr3, udimm, dual rank and eight byte lanes
        prepare_run(-1, 8'h0B, 8'h02, 8'h08, 8'h03);
        begin_test();
        apply_reset();
        end_test("reset state");

        begin_test();
        while (!addr_found && !read_err) @(negedge clk);
        check_flag("o_addr_found", addr_found, 1'b1);
        if (rx_count != addr_line_len) begin
            $display("address line had %0d characters when o_addr_found rose", rx_count);
            err_count++;
        end
        end_test("address scan");

        begin_test();
        while (!read_done && !read_err) @(negedge clk);
        check_flag("o_read_done", read_done, 1'b1);
        check_flag("o_read_err", read_err, 1'b0);
        repeat (20) @(negedge clk);
        if (exp_dev_q.size() != 0) begin
            $display("%0d bus requests never arrived", exp_dev_q.size());
            err_count++;
        end
        end_test("read order");

        begin_test();
        if (exp_char_q.size() != 0) begin
            $display("%0d uart characters never arrived", exp_char_q.size());
            err_count++;
        end
        end_test("decoded text");

        // second run with a non-ddr3 type, unknown module and lane codes and an abort at byte 10
        prepare_run(10, 8'h0C, 8'h05, 8'h10, 8'h06);
        begin_test();
        apply_reset();
        while (!read_err && !read_done) @(negedge clk);
        check_flag("o_read_err", read_err, 1'b1);
        check_flag("o_read_done", read_done, 1'b0);
        repeat (50) @(negedge clk);
        check_flag("o_rd_req after abort", rd_req, 1'b0);
        check_flag("o_read_done after abort", read_done, 1'b0);
        if (exp_dev_q.size() != 0 || exp_char_q.size() != 0) begin
            $display("abort run left %0d requests and %0d characters outstanding",
                     exp_dev_q.size(), exp_char_q.size());
            err_count++;
        end
        end_test("nack abort");

        $display("%0d of %0d tests passed, %0d errors in total",
                 tests_run - tests_failed, tests_run, err_count);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+.
spd_pkg.sv
text_pkg.sv
spd_scan_ctrl.sv
spd_line_fmt.sv
text_sender.sv
uart_tx_serial.sv
spd_reader.sv
tb_spd_reader.sv

// ==== Bender.yml ====
package:
  name: spd_reader

sources:
  - include_dirs:
      - .
    files:
      - spd_pkg.sv
      - text_pkg.sv
      - spd_scan_ctrl.sv
      - spd_line_fmt.sv
      - text_sender.sv
      - uart_tx_serial.sv
      - spd_reader.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_spd_reader.sv
